// ==== design/rsa_pkg.sv ====
`default_nettype none

// shared types for the modexp engine
package rsa_pkg;

    // bit positions and iteration steps
    // caps WIDTH at 65535
    typedef logic [15:0] step_cnt_t;

    // result credits held by the engine
    typedef logic [3:0] credit_cnt_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        ENTER,
        SCAN,
        SQUARE,
        MULT,
        EXIT,
        WAIT_CREDIT,
        SEND
    } ctrl_state_t;

    // result buffer slots at the consumer
    localparam credit_cnt_t DEFAULT_RES_CREDITS = credit_cnt_t'(2);

endpackage

`default_nettype wire

// ==== design/mont_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

// bit-serial montgomery product
// p = x * y * 2^-WIDTH mod n, all operands below n
module mont_mult import rsa_pkg::*; #(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic [WIDTH-1:0] i_x,
    input  wire logic [WIDTH-1:0] i_y,
    input  wire logic [WIDTH-1:0] i_n,
    output logic                  o_done,
    output logic      [WIDTH-1:0] o_p
);

    // operands, captured on start
    // x is shifted down one bit per step
    logic [WIDTH-1:0] x_q;
    logic [WIDTH-1:0] y_q;
    logic [WIDTH-1:0] n_q;
    // running sum, stays below 2n between steps
    logic [WIDTH+1:0] acc_q;
    logic [WIDTH+1:0] sum_y;
    logic [WIDTH+1:0] sum_n;
    logic [WIDTH+1:0] acc_red;
    step_cnt_t        step_q;
    logic             busy_q;
    // set for the final subtraction cycle
    logic             last_q;

    always_comb begin
        // add y when the current bit of x is set
        sum_y = acc_q + (x_q[0] ? {2'b00, y_q} : '0);
        // add n on an odd sum so the halving is exact
        sum_n = sum_y + (sum_y[0] ? {2'b00, n_q} : '0);
        // one subtraction brings acc below n
        acc_red = (acc_q >= {2'b00, n_q}) ? acc_q - {2'b00, n_q} : acc_q;
    end

    // sequencing: idle, WIDTH steps, one reduce cycle
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            busy_q <= 1'b0;
            last_q <= 1'b0;
            step_q <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy_q) begin
                if (i_start) begin
                    busy_q <= 1'b1;
                    last_q <= 1'b0;
                    step_q <= '0;
                end
            end else if (!last_q) begin
                step_q <= step_q + 16'd1;
                // last iteration step
                if (step_q == step_cnt_t'(WIDTH - 1)) begin
                    last_q <= 1'b1;
                end
            end else begin
                busy_q <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge i_clk) begin
        if (!busy_q && i_start) begin
            x_q   <= i_x;
            y_q   <= i_y;
            n_q   <= i_n;
            acc_q <= '0;
        end else if (busy_q && !last_q) begin
            x_q   <= x_q >> 1;
            acc_q <= sum_n >> 1;
        end else if (busy_q) begin
            // product held until the next start
            o_p <= acc_red[WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/mont_domain_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

// maps a into montgomery form, r = a * 2^WIDTH mod n
// one doubling and conditional subtract per cycle
module mont_domain_entry import rsa_pkg::*; #(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic [WIDTH-1:0] i_a,
    input  wire logic [WIDTH-1:0] i_n,
    output logic                  o_done,
    output logic      [WIDTH-1:0] o_r
);

    logic [WIDTH-1:0] n_q;
    // doubled value needs one extra bit
    logic [WIDTH:0]   dbl;
    logic [WIDTH:0]   dbl_red;
    step_cnt_t        step_q;
    logic             busy_q;

    always_comb begin
        dbl = {o_r, 1'b0};
        // value below n, so 2*value below 2n
        dbl_red = (dbl >= {1'b0, n_q}) ? dbl - {1'b0, n_q} : dbl;
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            busy_q <= 1'b0;
            step_q <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy_q) begin
                if (i_start) begin
                    busy_q <= 1'b1;
                    step_q <= '0;
                end
            end else begin
                step_q <= step_q + 16'd1;
                // done together with the last doubling
                if (step_q == step_cnt_t'(WIDTH - 1)) begin
                    busy_q <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // working value doubles as the held result
    always_ff @(posedge i_clk) begin
        if (!busy_q && i_start) begin
            o_r <= i_a;
            n_q <= i_n;
        end else if (busy_q) begin
            o_r <= dbl_red[WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/rsa_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// modexp control: job intake, exponent scan, operand select, credits
module rsa_ctrl import rsa_pkg::*; #(
    parameter int          WIDTH       = 256,
    parameter credit_cnt_t RES_CREDITS = DEFAULT_RES_CREDITS
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_job_valid,
    input  wire logic [WIDTH-1:0] i_n,
    input  wire logic [WIDTH-1:0] i_a,
    input  wire logic [WIDTH-1:0] i_e,
    output logic                  o_job_credit,
    input  wire logic             i_res_credit,
    output logic                  o_res_valid,
    output logic      [WIDTH-1:0] o_res,
    output logic                  o_mm_start,
    output logic      [WIDTH-1:0] o_mm_x,
    output logic      [WIDTH-1:0] o_mm_y,
    input  wire logic             i_mm_done,
    input  wire logic [WIDTH-1:0] i_mm_p,
    output logic                  o_de_start,
    input  wire logic             i_de_done,
    input  wire logic [WIDTH-1:0] i_de_r,
    output logic      [WIDTH-1:0] o_n
);

    ctrl_state_t      state_q;
    credit_cnt_t      credit_q;
    // exponent, shifted up so the next bit sits at the top
    logic [WIDTH-1:0] e_q;
    // exponent bits still to process
    step_cnt_t        bits_q;
    // job copy and montgomery values
    logic [WIDTH-1:0] n_q;
    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] base_q;
    logic [WIDTH-1:0] acc_q;
    logic [WIDTH-1:0] res_q;

    // send and job credit return share the SEND cycle
    assign o_res_valid  = (state_q == SEND);
    assign o_job_credit = (state_q == SEND);
    assign o_res        = res_q;
    assign o_n          = n_q;

    // operand bus, also carries a to the entry unit
    always_comb begin
        o_mm_x = acc_q;
        o_mm_y = acc_q;
        case (state_q)
            ENTER: begin
                o_mm_x = a_q;
                o_mm_y = '0;
            end
            MULT:    o_mm_y = base_q;
            // product by 1 leaves montgomery form
            EXIT:    o_mm_y = WIDTH'(1);
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_q    <= IDLE;
            credit_q   <= RES_CREDITS;
            e_q        <= '0;
            bits_q     <= '0;
            o_mm_start <= 1'b0;
            o_de_start <= 1'b0;
        end else begin
            o_mm_start <= 1'b0;
            o_de_start <= 1'b0;
            // return and send in one cycle cancel out
            credit_q <= credit_q + credit_cnt_t'(i_res_credit)
                        - credit_cnt_t'(o_res_valid);
            case (state_q)
                IDLE: begin
                    if (i_job_valid) begin
                        e_q    <= i_e;
                        bits_q <= step_cnt_t'(WIDTH - 1);
                        // zero exponent skips the multiplier
                        if (i_e == '0) begin
                            state_q <= WAIT_CREDIT;
                        end else begin
                            state_q    <= ENTER;
                            o_de_start <= 1'b1;
                        end
                    end
                end
                ENTER: begin
                    // find the top set bit while entry runs
                    if (!e_q[WIDTH-1]) begin
                        e_q    <= e_q << 1;
                        bits_q <= bits_q - 16'd1;
                    end
                    if (i_de_done) begin
                        state_q <= SCAN;
                    end
                end
                SCAN: begin
                    o_mm_start <= 1'b1;
                    if (bits_q == '0) begin
                        state_q <= EXIT;
                    end else begin
                        e_q     <= e_q << 1;
                        bits_q  <= bits_q - 16'd1;
                        state_q <= SQUARE;
                    end
                end
                SQUARE: begin
                    if (i_mm_done) begin
                        // multiply only on a set bit
                        if (e_q[WIDTH-1]) begin
                            state_q    <= MULT;
                            o_mm_start <= 1'b1;
                        end else begin
                            state_q <= SCAN;
                        end
                    end
                end
                MULT: begin
                    if (i_mm_done) begin
                        state_q <= SCAN;
                    end
                end
                EXIT: begin
                    if (i_mm_done) begin
                        state_q <= WAIT_CREDIT;
                    end
                end
                // back-pressure holds here
                WAIT_CREDIT: begin
                    if (credit_q != '0) begin
                        state_q <= SEND;
                    end
                end
                SEND:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // job copy and accumulator
    always_ff @(posedge i_clk) begin
        case (state_q)
            IDLE: begin
                if (i_job_valid) begin
                    n_q   <= i_n;
                    a_q   <= i_a;
                    res_q <= WIDTH'(1);
                end
            end
            ENTER: begin
                if (i_de_done) begin
                    base_q <= i_de_r;
                    acc_q  <= i_de_r;
                end
            end
            SQUARE, MULT: begin
                if (i_mm_done) begin
                    acc_q <= i_mm_p;
                end
            end
            EXIT: begin
                if (i_mm_done) begin
                    res_q <= i_mm_p;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rsa_modexp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// rsa modular exponentiation engine
// one job in flight, credit flow control on both sides
module rsa_modexp_top import rsa_pkg::*; #(
    parameter int          WIDTH       = 256,
    parameter credit_cnt_t RES_CREDITS = DEFAULT_RES_CREDITS
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_job_valid,
    input  wire logic [WIDTH-1:0] i_n,
    input  wire logic [WIDTH-1:0] i_a,
    input  wire logic [WIDTH-1:0] i_e,
    output logic                  o_job_credit,
    input  wire logic             i_res_credit,
    output logic                  o_res_valid,
    output logic      [WIDTH-1:0] o_res
);

    // multiplier handshake
    logic             mm_start;
    logic [WIDTH-1:0] mm_x;
    logic [WIDTH-1:0] mm_y;
    logic             mm_done;
    logic [WIDTH-1:0] mm_p;
    // entry handshake
    logic             de_start;
    logic             de_done;
    logic [WIDTH-1:0] de_r;
    // registered modulus
    logic [WIDTH-1:0] n_reg;

    rsa_ctrl #(
        .WIDTH       (WIDTH),
        .RES_CREDITS (RES_CREDITS)
    ) rsa_ctrl_inst (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_job_valid  (i_job_valid),
        .i_n          (i_n),
        .i_a          (i_a),
        .i_e          (i_e),
        .o_job_credit (o_job_credit),
        .i_res_credit (i_res_credit),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .o_mm_start   (mm_start),
        .o_mm_x       (mm_x),
        .o_mm_y       (mm_y),
        .i_mm_done    (mm_done),
        .i_mm_p       (mm_p),
        .o_de_start   (de_start),
        .i_de_done    (de_done),
        .i_de_r       (de_r),
        .o_n          (n_reg)
    );

    mont_mult #(
        .WIDTH (WIDTH)
    ) mont_mult_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mm_start),
        .i_x     (mm_x),
        .i_y     (mm_y),
        .i_n     (n_reg),
        .o_done  (mm_done),
        .o_p     (mm_p)
    );

    // base arrives on the shared x operand bus
    mont_domain_entry #(
        .WIDTH (WIDTH)
    ) mont_domain_entry_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (de_start),
        .i_a     (mm_x),
        .i_n     (n_reg),
        .o_done  (de_done),
        .o_r     (de_r)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running clock and power-on reset
module tb_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // active low, released on a falling edge
    initial begin
        o_rst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/rsa_ctrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// controller checks, bound into rsa_ctrl
module rsa_ctrl_assertions import rsa_pkg::*; #(
    parameter credit_cnt_t RES_CREDITS = DEFAULT_RES_CREDITS
) (
    input wire logic        i_clk,
    input wire logic        i_rst,
    input wire credit_cnt_t i_credit,
    input wire logic        i_res_valid,
    input wire logic        i_mm_start,
    input wire logic        i_mm_done,
    input wire logic        i_de_start,
    input wire logic        i_de_done
);

    // failed checks, read by the testbench
    int   fail_cnt = 0;
    // unit busy from the start edge up to its done pulse
    logic mm_busy_q;
    logic de_busy_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            mm_busy_q <= 1'b0;
            de_busy_q <= 1'b0;
        end else begin
            if (i_mm_start) begin
                mm_busy_q <= 1'b1;
            end else if (i_mm_done) begin
                mm_busy_q <= 1'b0;
            end
            if (i_de_start) begin
                de_busy_q <= 1'b1;
            end else if (i_de_done) begin
                de_busy_q <= 1'b0;
            end
        end
    end

    // no send without a result credit
    a_send_credit: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_res_valid |-> (i_credit != '0))
    else begin
        $error("result sent with zero result credits");
        fail_cnt++;
    end

    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_credit <= RES_CREDITS)
    else begin
        $error("result credit count above its reset value");
        fail_cnt++;
    end

    // done cycle counts as idle, the unit is free again
    a_mm_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_mm_start |-> (!mm_busy_q || i_mm_done))
    else begin
        $error("multiplier started while busy");
        fail_cnt++;
    end

    a_de_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_de_start |-> (!de_busy_q || i_de_done))
    else begin
        $error("domain entry started while busy");
        fail_cnt++;
    end

    // single cycle send
    a_res_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_res_valid |=> !i_res_valid)
    else begin
        $error("result valid held longer than one cycle");
        fail_cnt++;
    end

endmodule

bind rsa_ctrl rsa_ctrl_assertions #(
    .RES_CREDITS (RES_CREDITS)
) rsa_ctrl_assertions_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_credit    (credit_q),
    .i_res_valid (o_res_valid),
    .i_mm_start  (o_mm_start),
    .i_mm_done   (i_mm_done),
    .i_de_start  (o_de_start),
    .i_de_done   (i_de_done)
);

`default_nettype wire

// ==== verif/rsa_modexp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the modexp engine with 64-bit operands
module rsa_modexp_tb import rsa_pkg::*; ();

    localparam int          WIDTH           = 64;
    localparam int          NUM_RES_CREDITS = 2;
    localparam credit_cnt_t RES_CREDITS     = credit_cnt_t'(NUM_RES_CREDITS);
    // longest job, about 2*WIDTH+2 products of WIDTH+4 cycles
    localparam int FULL_JOB_CYCLES = (2 * WIDTH + 2) * (WIDTH + 4);
    localparam int STALL_CYCLES    = FULL_JOB_CYCLES + WIDTH;
    localparam int JOB_TIMEOUT     = 2 * FULL_JOB_CYCLES;
    localparam int NUM_RANDOM      = 8;

    logic             clk;
    logic             rst;
    logic             job_valid;
    logic [WIDTH-1:0] job_n;
    logic [WIDTH-1:0] job_a;
    logic [WIDTH-1:0] job_e;
    logic             job_credit;
    logic             res_credit;
    logic             res_valid;
    logic [WIDTH-1:0] res;

    // table columns: modulus, base, exponent, return credits, expected
    logic [WIDTH-1:0] tbl_n[$];
    logic [WIDTH-1:0] tbl_a[$];
    logic [WIDTH-1:0] tbl_e[$];
    bit               tbl_ret[$];
    logic [127:0]     tbl_exp[$];

    integer seed;
    // credits as the testbench tracks them
    int     engine_credits;

    tb_clkgen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (3)
    ) tb_clkgen_inst (
        .o_clk (clk),
        .o_rst (rst)
    );

    rsa_modexp_top #(
        .WIDTH       (WIDTH),
        .RES_CREDITS (RES_CREDITS)
    ) rsa_modexp_top_inst (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_job_valid  (job_valid),
        .i_n          (job_n),
        .i_a          (job_a),
        .i_e          (job_e),
        .o_job_credit (job_credit),
        .i_res_credit (res_credit),
        .o_res_valid  (res_valid),
        .o_res        (res)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic int assertion_failures();
        return rsa_modexp_top_inst.rsa_ctrl_inst.rsa_ctrl_assertions_inst.fail_cnt;
    endfunction

    // plain square-and-multiply, 128-bit products
    function automatic logic [127:0] modexp_ref(input logic [WIDTH-1:0] base,
                                                input logic [WIDTH-1:0] exp_val,
                                                input logic [WIDTH-1:0] modn);
        logic [127:0] m;
        logic [127:0] b;
        logic [127:0] r;
        int           i;
        m = {{(128 - WIDTH){1'b0}}, modn};
        b = {{(128 - WIDTH){1'b0}}, base} % m;
        r = 128'd1 % m;
        for (i = WIDTH - 1; i >= 0; i--) begin
            r = (r * r) % m;
            if (exp_val[i]) begin
                r = (r * b) % m;
            end
        end
        return r;
    endfunction

    task automatic add_job(input logic [WIDTH-1:0] mod_val, input logic [WIDTH-1:0] base,
                           input logic [WIDTH-1:0] exp_val, input bit ret);
        tbl_n.push_back(mod_val);
        tbl_a.push_back(base);
        tbl_e.push_back(exp_val);
        tbl_ret.push_back(ret);
        tbl_exp.push_back(modexp_ref(base, exp_val, mod_val));
    endtask

    task automatic add_random_job(input bit ret);
        logic [WIDTH-1:0] rn;
        logic [WIDTH-1:0] ra;
        logic [WIDTH-1:0] re;
        rn = {$random(seed), $random(seed)};
        // full width and odd
        rn[WIDTH-1] = 1'b1;
        rn[0]       = 1'b1;
        ra = {$random(seed), $random(seed)};
        ra = ra % rn;
        re = {$random(seed), $random(seed)};
        add_job(rn, ra, re, ret);
    endtask

    task automatic build_table();
        int i;
        add_job(64'd3, 64'd2, 64'd5, 1'b1);
        add_job(64'd97, 64'd5, 64'd1, 1'b1);
        add_job(64'd101, 64'd0, 64'd77, 1'b1);
        add_job(64'd143, 64'd7, 64'd0, 1'b1);
        add_job(64'd3, 64'd1, 64'hffff_ffff_ffff_ffff, 1'b1);
        // largest 64-bit prime, (N-1)^2 is 1
        add_job(64'hffff_ffff_ffff_ffc5, 64'hffff_ffff_ffff_ffc4, 64'd2, 1'b1);
        for (i = 0; i < NUM_RANDOM; i++) begin
            add_random_job(1'b1);
        end
        // credits withheld, two results fill the consumer
        add_random_job(1'b0);
        add_job(64'd1009, 64'd17, 64'd0, 1'b0);
        // third result has to wait for a credit
        add_random_job(1'b1);
        add_random_job(1'b1);
        add_random_job(1'b1);
        add_random_job(1'b1);
    endtask

    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (!rst && cnt < 10) begin
            @(negedge clk);
            cnt++;
        end
        if (!rst) begin
            fail_run("reset was never released");
        end
    endtask

    // one cycle pulse, then one quiet cycle
    task automatic return_credit();
        res_credit = 1'b1;
        @(negedge clk);
        res_credit = 1'b0;
        engine_credits++;
        @(negedge clk);
    endtask

    task automatic hold_without_credit();
        int cnt;
        for (cnt = 0; cnt < STALL_CYCLES; cnt++) begin
            @(negedge clk);
            if (res_valid) begin
                fail_run("result sent while the engine held no result credit");
            end
        end
    endtask

    task automatic run_job(input int idx);
        int cnt;
        @(negedge clk);
        job_valid = 1'b1;
        job_n     = tbl_n[idx];
        job_a     = tbl_a[idx];
        job_e     = tbl_e[idx];
        @(negedge clk);
        job_valid = 1'b0;
        // engine works from its own copy
        job_n = ~job_n;
        job_a = ~job_a;
        job_e = ~job_e;
        if (engine_credits == 0) begin
            hold_without_credit();
            return_credit();
        end
        cnt = 0;
        while (!res_valid && cnt < JOB_TIMEOUT) begin
            if (job_credit) begin
                fail_run($sformatf("job credit returned before result of job %0d", idx));
            end
            @(negedge clk);
            cnt++;
        end
        if (!res_valid) begin
            fail_run($sformatf("no result for job %0d within %0d cycles", idx, JOB_TIMEOUT));
        end
        check_value("o_res", 128'(res), tbl_exp[idx]);
        check_value("o_job_credit", 128'(job_credit), 128'd1);
        engine_credits--;
        // first return lands in the send cycle itself
        if (tbl_ret[idx]) begin
            while (engine_credits < NUM_RES_CREDITS) begin
                return_credit();
            end
        end
        if (assertion_failures() != 0) begin
            fail_run($sformatf("controller assertion failed during job %0d", idx));
        end
    endtask

    initial begin
        int cnt;
        int idx;
        job_valid      = 1'b0;
        job_n          = '0;
        job_a          = '0;
        job_e          = '0;
        res_credit     = 1'b0;
        seed           = 32'ha3192390;
        engine_credits = NUM_RES_CREDITS;
        build_table();
        wait_reset_release();
        // idle engine stays quiet
        for (cnt = 0; cnt < 20; cnt++) begin
            @(negedge clk);
            check_value("o_res_valid", 128'(res_valid), 128'd0);
            check_value("o_job_credit", 128'(job_credit), 128'd0);
        end
        for (idx = 0; idx < tbl_n.size(); idx++) begin
            run_job(idx);
        end
        if (assertion_failures() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run("controller assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/rsa_pkg.sv
design/mont_mult.sv
design/mont_domain_entry.sv
design/rsa_ctrl.sv
design/rsa_modexp_top.sv
verif/tb_clkgen.sv
verif/rsa_ctrl_assertions.sv
verif/rsa_modexp_tb.sv

// ==== Makefile ====
TOP := rsa_modexp_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f
	out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
